/* hdl/interp_types_pkg.sv */
`default_nettype none

package interp_types_pkg;

    // Screen position and attribute widths
    localparam int COORD_W = 11;
    localparam int ATTR_W  = 32;
    localparam int COLOR_W = 32;
    localparam int INDEX_W = 32;

    typedef logic [COORD_W-1:0]        coord_t;
    typedef logic signed [ATTR_W-1:0]  attr_t;
    typedef logic [COLOR_W-1:0]        color_t;
    typedef logic [INDEX_W-1:0]        index_t;

    // One attribute plane, value = base + x*dx + y*dy
    typedef struct packed {
        attr_t base;
        attr_t dx;
        attr_t dy;
    } plane_t;

    // Pixel as delivered by the rasterizer
    typedef struct packed {
        coord_t x;
        coord_t y;
        plane_t plane_s, plane_t, plane_w;
        color_t color;
        index_t fb_index;
        logic   last;
    } pixel_in_t;

    // Interpolated pixel toward the fragment stage
    typedef struct packed {
        attr_t  s;
        attr_t  t;
        attr_t  w;
        color_t color;
        index_t fb_index;
        logic   last;
    } pixel_out_t;

endpackage

`default_nettype wire

/* hdl/interp_flow_pkg.sv */
`default_nettype none

package interp_flow_pkg;

    // Register stages from pipe input to result
    localparam int PIPE_DEPTH  = 3;

    // Output buffer size, equal to the source credits after reset
    localparam int FIFO_DEPTH  = 8;

    // Credits granted by the sink after reset
    localparam int OUT_CREDITS = 4;

    localparam int PTR_W    = $clog2(FIFO_DEPTH);
    localparam int FILL_W   = $clog2(FIFO_DEPTH + 1);
    localparam int CREDIT_W = $clog2(OUT_CREDITS + 1);

    typedef logic [PTR_W-1:0]    fifo_ptr_t;
    typedef logic [FILL_W-1:0]   fill_t;
    typedef logic [CREDIT_W-1:0] credit_t;

endpackage

`default_nettype wire

/* hdl/plane_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module plane_eval
(
    input  wire                      clk,
    input  wire                      rst,
    input  wire interp_types_pkg::coord_t x,
    input  wire interp_types_pkg::coord_t y,
    input  wire interp_types_pkg::plane_t plane,
    output interp_types_pkg::attr_t  value
);

    localparam int PAD_W = interp_types_pkg::ATTR_W - interp_types_pkg::COORD_W;

    // Coordinates zero extended to attribute width
    interp_types_pkg::attr_t x_ext;
    interp_types_pkg::attr_t y_ext;

    interp_types_pkg::attr_t prod_x;
    interp_types_pkg::attr_t prod_y;
    interp_types_pkg::attr_t base_d1;
    interp_types_pkg::attr_t sum_xy;
    interp_types_pkg::attr_t base_d2;

    assign x_ext = interp_types_pkg::attr_t'({{PAD_W{1'b0}}, x});
    assign y_ext = interp_types_pkg::attr_t'({{PAD_W{1'b0}}, y});

    ////////////////////
    // Stage 1 products
    ////////////////////
    always_ff @(posedge clk)
    begin
        // Low 32 bits of the product, wraps modulo 2^32
        prod_x  <= x_ext * plane.dx;
        prod_y  <= y_ext * plane.dy;
        base_d1 <= plane.base;
    end

    ////////////////////
    // Stage 2 increment sum
    ////////////////////
    always_ff @(posedge clk)
    begin
        sum_xy  <= prod_x + prod_y;
        base_d2 <= base_d1;
    end

    // Stage 3 adds the base
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            value <= '0;
        end
        else
        begin
            value <= sum_xy + base_d2;
        end
    end

endmodule

`default_nettype wire

/* hdl/pixel_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_pipe
(
    input  wire                             clk,
    input  wire                             rst,
    input  wire logic                       in_valid,
    input  wire interp_types_pkg::pixel_in_t in_pixel,
    output logic                            res_valid,
    output interp_types_pkg::pixel_out_t    res_pixel
);

    localparam int DEPTH = interp_flow_pkg::PIPE_DEPTH;

    // Fields that pass through untouched
    typedef struct packed {
        interp_types_pkg::color_t color;
        interp_types_pkg::index_t fb_index;
        logic                     last;
    } sideband_t;

    logic [DEPTH-1:0] valid_sr;
    sideband_t        side_sr [DEPTH];
    sideband_t        side_in;

    interp_types_pkg::attr_t val_s;
    interp_types_pkg::attr_t val_t;
    interp_types_pkg::attr_t val_w;

    ////////////////////
    // Plane evaluators
    ////////////////////
    plane_eval u_eval_s
    (
        .clk   (clk),
        .rst   (rst),
        .x     (in_pixel.x),
        .y     (in_pixel.y),
        .plane (in_pixel.plane_s),
        .value (val_s)
    );

    plane_eval u_eval_t
    (
        .clk   (clk),
        .rst   (rst),
        .x     (in_pixel.x),
        .y     (in_pixel.y),
        .plane (in_pixel.plane_t),
        .value (val_t)
    );

    plane_eval u_eval_w
    (
        .clk   (clk),
        .rst   (rst),
        .x     (in_pixel.x),
        .y     (in_pixel.y),
        .plane (in_pixel.plane_w),
        .value (val_w)
    );

    ////////////////////
    // Sideband alignment
    ////////////////////
    assign side_in = '{color: in_pixel.color, fb_index: in_pixel.fb_index, last: in_pixel.last};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            valid_sr <= '0;
        end
        else
        begin
            valid_sr <= {valid_sr[DEPTH-2:0], in_valid};
        end
    end

    // Same depth as the plane evaluators
    always_ff @(posedge clk)
    begin
        side_sr[0] <= side_in;
        for (int i = 1; i < DEPTH; i++)
        begin
            side_sr[i] <= side_sr[i-1];
        end
    end

    assign res_valid = valid_sr[DEPTH-1];

    always_comb
    begin
        res_pixel.s        = val_s;
        res_pixel.t        = val_t;
        res_pixel.w        = val_w;
        res_pixel.color    = side_sr[DEPTH-1].color;
        res_pixel.fb_index = side_sr[DEPTH-1].fb_index;
        res_pixel.last     = side_sr[DEPTH-1].last;
    end

endmodule

`default_nettype wire

/* hdl/credit_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module credit_fifo
(
    input  wire                              clk,
    input  wire                              rst,
    input  wire logic                        wr_valid,
    input  wire interp_types_pkg::pixel_out_t wr_pixel,
    input  wire logic                        in_valid,
    input  wire logic                        out_credit,
    output logic                             in_credit,
    output logic                             out_valid,
    output interp_types_pkg::pixel_out_t     out_pixel,
    output logic                             busy
);

    localparam int DEPTH = interp_flow_pkg::FIFO_DEPTH;

    interp_types_pkg::pixel_out_t mem [DEPTH];

    interp_flow_pkg::fifo_ptr_t wr_ptr;
    interp_flow_pkg::fifo_ptr_t rd_ptr;
    interp_flow_pkg::fill_t     count;
    interp_flow_pkg::fill_t     inflight;
    interp_flow_pkg::credit_t   credits;
    interp_flow_pkg::credit_t   sink_held;

    logic do_pop;

    // One entry leaves per cycle while the sink has room
    assign do_pop = (count != '0) && (credits != '0);

    ////////////////////
    // Storage
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (wr_valid)
        begin
            mem[wr_ptr] <= wr_pixel;
        end
        if (do_pop)
        begin
            out_pixel <= mem[rd_ptr];
        end
    end

    ////////////////////
    // Pointers and counters
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            inflight  <= '0;
            credits   <= interp_flow_pkg::credit_t'(interp_flow_pkg::OUT_CREDITS);
            sink_held <= '0;
            out_valid <= 1'b0;
            in_credit <= 1'b0;
        end
        else
        begin
            if (wr_valid)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count + interp_flow_pkg::fill_t'(wr_valid)
                        - interp_flow_pkg::fill_t'(do_pop);
            // Pixels accepted at the input and not yet popped
            inflight <= inflight + interp_flow_pkg::fill_t'(in_valid)
                        - interp_flow_pkg::fill_t'(do_pop);
            credits  <= credits + interp_flow_pkg::credit_t'(out_credit)
                        - interp_flow_pkg::credit_t'(do_pop);
            // Pixels sent to the sink whose credit has not come back yet
            sink_held <= sink_held + interp_flow_pkg::credit_t'(out_valid)
                         - interp_flow_pkg::credit_t'(out_credit);
            // A pop frees one slot, handed back to the source
            out_valid <= do_pop;
            in_credit <= do_pop;
        end
    end

    // High until the last popped pixel has left
    assign busy = (inflight != '0) || out_valid;

    ////////////////////
    // Protocol checks
    ////////////////////
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> (count != interp_flow_pkg::fill_t'(DEPTH)));

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= interp_flow_pkg::credit_t'(interp_flow_pkg::OUT_CREDITS));

    a_valid_has_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> (sink_held < interp_flow_pkg::credit_t'(interp_flow_pkg::OUT_CREDITS)));

endmodule

`default_nettype wire

/* hdl/attr_interpolator.sv */
`timescale 1ns/1ps
`default_nettype none

module attr_interpolator
(
    input  wire                             clk,
    input  wire                             rst,

    // Pixel stream from the rasterizer
    input  wire logic                       in_valid,
    input  wire interp_types_pkg::pixel_in_t in_pixel,
    output logic                            in_credit,

    // Interpolated pixel stream
    output logic                            out_valid,
    output interp_types_pkg::pixel_out_t    out_pixel,
    input  wire logic                       out_credit,

    // Any pixel still inside
    output logic                            busy
);

    logic                         res_valid;
    interp_types_pkg::pixel_out_t res_pixel;

    ////////////////////
    // Interpolation pipe
    ////////////////////
    pixel_pipe u_pipe
    (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_pixel  (in_pixel),
        .res_valid (res_valid),
        .res_pixel (res_pixel)
    );

    ////////////////////
    // Output buffer and credits
    ////////////////////
    // Sized so that every pixel the source may send finds a slot
    credit_fifo u_fifo
    (
        .clk        (clk),
        .rst        (rst),
        .wr_valid   (res_valid),
        .wr_pixel   (res_pixel),
        .in_valid   (in_valid),
        .out_credit (out_credit),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .busy       (busy)
    );

endmodule

`default_nettype wire

/* tests/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

////////////////////
// Compare tasks
////////////////////
task automatic compare_pixel(input string name,
                             input interp_types_pkg::pixel_out_t actual,
                             input interp_types_pkg::pixel_out_t expected);
    if (actual !== expected)
    begin
        stop_with_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
endtask

task automatic compare_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
        stop_with_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
endtask

task automatic compare_count(input string name,
                             input interp_flow_pkg::fill_t actual,
                             input interp_flow_pkg::fill_t expected);
    if (actual !== expected)
    begin
        stop_with_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected));
    end
endtask

////////////////////
// Reference model
////////////////////
// base + x*dx + y*dy, kept to the low 32 bits
function automatic interp_types_pkg::attr_t model_plane(input interp_types_pkg::coord_t x,
                                                        input interp_types_pkg::coord_t y,
                                                        input interp_types_pkg::plane_t p);
    logic [31:0] sum;
    sum = p.base + 32'(x) * p.dx + 32'(y) * p.dy;
    return sum;
endfunction

function automatic interp_types_pkg::pixel_out_t model_pixel(
    input interp_types_pkg::pixel_in_t p);
    interp_types_pkg::pixel_out_t r;
    r.s        = model_plane(p.x, p.y, p.plane_s);
    r.t        = model_plane(p.x, p.y, p.plane_t);
    r.w        = model_plane(p.x, p.y, p.plane_w);
    r.color    = p.color;
    r.fb_index = p.fb_index;
    r.last     = p.last;
    return r;
endfunction

task automatic send_pixel(input interp_types_pkg::pixel_in_t p);
    send_q.push_back(p);
    expect_q.push_back(model_pixel(p));
endtask

task automatic make_random_pixel(input logic last, output interp_types_pkg::pixel_in_t p);
    logic [31:0] r;
    r                = $random(seed);
    p.x              = r[10:0];
    p.y              = r[26:16];
    p.plane_s.base   = $random(seed);
    p.plane_s.dx     = $random(seed);
    p.plane_s.dy     = $random(seed);
    p.plane_t.base   = $random(seed);
    p.plane_t.dx     = $random(seed);
    p.plane_t.dy     = $random(seed);
    p.plane_w.base   = $random(seed);
    p.plane_w.dx     = $random(seed);
    p.plane_w.dy     = $random(seed);
    p.color          = $random(seed);
    p.fb_index       = $random(seed);
    p.last           = last;
endtask

// Queues empty and every credit back home on both sides
task automatic wait_idle();
    int cycles;
    cycles = 0;
    while (send_q.size() != 0 || expect_q.size() != 0 || owed_credits != 0
           || src_credits != interp_flow_pkg::FIFO_DEPTH)
    begin
        @(negedge clk);
        cycles++;
        if (cycles > 400)
        begin
            stop_with_failure("DUT did not drain its pixels in time");
        end
    end
    repeat (2) @(negedge clk);
endtask

////////////////////
// Directed tests
////////////////////
task automatic check_reset_state();
    compare_bit("out_valid", out_valid, 1'b0);
    compare_bit("in_credit", in_credit, 1'b0);
    compare_bit("busy", busy, 1'b0);
endtask

task automatic test_single_pixel();
    interp_types_pkg::pixel_in_t p;
    p          = '0;
    p.x        = 11'd37;
    p.y        = 11'd5;
    p.plane_s  = '{base: 32'sd1000, dx: -32'sd3, dy: 32'sd7};
    p.plane_t  = '{base: -32'sd50000, dx: 32'sd1234, dy: -32'sd4321};
    // Large base so that the sum wraps past 2^31
    p.plane_w  = '{base: 32'sh7fff_fff0, dx: 32'sh0010_0000, dy: 32'sd1};
    p.color    = 32'hc0ff_ee11;
    p.fb_index = 32'd12345;
    p.last     = 1'b1;
    send_pixel(p);
    wait_idle();
endtask

task automatic test_random_burst();
    interp_types_pkg::pixel_in_t p;
    for (int i = 0; i < 32; i++)
    begin
        make_random_pixel(i == 31, p);
        send_pixel(p);
    end
    wait_idle();
endtask

task automatic test_back_pressure();
    interp_types_pkg::pixel_in_t p;
    int out_base;
    int pulse_base;
    int cycles;
    sink_returns = 1'b0;
    out_base     = out_count;
    pulse_base   = credit_pulses;
    cycles       = 0;
    // 4 leave and 8 fill pipe and FIFO, so 2 stay with the source
    for (int i = 0; i < 14; i++)
    begin
        make_random_pixel(i == 13, p);
        send_pixel(p);
    end
    while (out_count - out_base < interp_flow_pkg::OUT_CREDITS || src_credits != 0)
    begin
        @(negedge clk);
        cycles++;
        if (cycles > 100)
        begin
            stop_with_failure("Source never ran out of credits under back-pressure");
        end
    end
    // Nothing may move while the sink holds its credits
    repeat (10) @(negedge clk);
    compare_count("out_valid count", interp_flow_pkg::fill_t'(out_count - out_base),
                  interp_flow_pkg::fill_t'(interp_flow_pkg::OUT_CREDITS));
    compare_count("in_credit count", interp_flow_pkg::fill_t'(credit_pulses - pulse_base),
                  interp_flow_pkg::fill_t'(interp_flow_pkg::OUT_CREDITS));
    compare_count("src_credits", interp_flow_pkg::fill_t'(src_credits), '0);
    compare_count("stalled pixels", interp_flow_pkg::fill_t'(send_q.size()),
                  interp_flow_pkg::fill_t'(2));
    compare_bit("out_valid", out_valid, 1'b0);
    sink_returns = 1'b1;
    wait_idle();
endtask

task automatic test_busy_flag();
    interp_types_pkg::pixel_in_t p;
    compare_bit("busy", busy, 1'b0);
    for (int i = 0; i < 3; i++)
    begin
        make_random_pixel(i == 2, p);
        send_pixel(p);
    end
    while (send_q.size() != 0)
    begin
        @(negedge clk);
    end
    @(negedge clk);
    while (expect_q.size() != 0)
    begin
        compare_bit("busy", busy, 1'b1);
        @(negedge clk);
    end
    // Last pixel gone and no new input
    @(negedge clk);
    compare_bit("busy", busy, 1'b0);
    wait_idle();
endtask

`endif

/* tests/tb_attr_interpolator.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_attr_interpolator;

    // Single pixel, random burst, back-pressure and busy tests
    localparam int TOTAL_PIXELS    = 1 + 32 + 14 + 3;
    localparam int WATCHDOG_CYCLES = TOTAL_PIXELS * 20 + 200;

    logic                         clk;
    logic                         rst;
    logic                         in_valid;
    interp_types_pkg::pixel_in_t  in_pixel;
    logic                         in_credit;
    logic                         out_valid;
    interp_types_pkg::pixel_out_t out_pixel;
    logic                         out_credit;
    logic                         busy;

    // Source side
    interp_types_pkg::pixel_in_t send_q [$];
    int src_credits;
    int credit_pulses;

    // Sink side
    interp_types_pkg::pixel_out_t expect_q [$];
    int   out_count;
    int   owed_credits;
    logic sink_returns;

    int seed;

    attr_interpolator u_dut
    (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_pixel   (in_pixel),
        .in_credit  (in_credit),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_credit (out_credit),
        .busy       (busy)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    ////////////////////
    // Source
    ////////////////////
    initial
    begin
        in_valid      = 1'b0;
        in_pixel      = '0;
        src_credits   = interp_flow_pkg::FIFO_DEPTH;
        credit_pulses = 0;
        forever
        begin
            @(negedge clk);
            if (in_credit === 1'b1)
            begin
                src_credits++;
                credit_pulses++;
            end
            if (src_credits > interp_flow_pkg::FIFO_DEPTH)
            begin
                stop_with_failure("DUT returned more input credits than the source spent");
            end
            // One pixel per cycle while a credit is held
            if (!rst && send_q.size() > 0 && src_credits > 0)
            begin
                in_pixel = send_q.pop_front();
                in_valid = 1'b1;
                src_credits--;
            end
            else
            begin
                in_valid = 1'b0;
            end
        end
    end

    ////////////////////
    // Sink
    ////////////////////
    initial
    begin
        out_credit   = 1'b0;
        out_count    = 0;
        owed_credits = 0;
        forever
        begin
            @(negedge clk);
            if (out_valid === 1'b1)
            begin
                if (expect_q.size() == 0)
                begin
                    stop_with_failure("DUT sent an output pixel that was never expected");
                end
                compare_pixel("out_pixel", out_pixel, expect_q.pop_front());
                out_count++;
                owed_credits++;
            end
            // Credits go back one per cycle once the test lets them
            if (sink_returns && owed_credits > 0)
            begin
                out_credit = 1'b1;
                owed_credits--;
            end
            else
            begin
                out_credit = 1'b0;
            end
        end
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("Watchdog expired before the tests finished");
    end

    initial
    begin
        rst          = 1'b1;
        sink_returns = 1'b1;
        seed         = 48214;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_reset_state();
        test_single_pixel();
        test_random_burst();
        test_back_pressure();
        test_busy_flag();

        $display("Simulation completed successfully");
        $finish;
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

`include "tb_checks.svh"

endmodule

`default_nettype wire

/* attr_interp.f */
+incdir+tests
hdl/interp_types_pkg.sv
hdl/interp_flow_pkg.sv
hdl/plane_eval.sv
hdl/pixel_pipe.sv
hdl/credit_fifo.sv
hdl/attr_interpolator.sv
tests/tb_attr_interpolator.sv

/* Makefile */
TOP = tb_attr_interpolator

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f attr_interp.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
